// File: logic/dmrw_cfg.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data access stage configuration
// IO region code, IO register count, memory size and memory wait cycles
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef DMRW_CFG_SVH
`define DMRW_CFG_SVH

// address bits 31:30 that select the IO block
`define DMRW_IO_REGION 2'd3

// word registers in the IO block, decoded from address bits 5:2
`define DMRW_IO_REGS 16

// data memory depth in words, wraps above address bit 9
`define DMRW_MEM_WORDS 256

// cycles from request to valid or finish pulse
`define DMRW_MEM_WAIT 4

`endif

// File: logic/dmrw_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data access stage types
// access size code, stage state encoding, data word
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package dmrw_pkg;

	typedef logic [31:0] word_t;

	// access size as it comes from funct3
	typedef logic [2:0] ldst_code_t;

	localparam ldst_code_t LDST_BYTE = 3'd0;
	localparam ldst_code_t LDST_HALF = 3'd1;
	localparam ldst_code_t LDST_WORD = 3'd2;

	// stage states, bit 2 marks the IO side
	typedef enum logic [2:0] {
		DAT_IDLE = 3'b000,
		DAT_READ = 3'b001,
		DAT_WRTE = 3'b010,
		DAT_IOR1 = 3'b101,
		DAT_IOR2 = 3'b111,
		DAT_IOWT = 3'b110
	} dat_state_t;

endpackage

// File: logic/data_rw_mem.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data access stage of the RV32I core
// region decode, memory and IO request generation, busy FSM,
// writeback data selection
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "dmrw_cfg.svh"

module data_rw_mem import dmrw_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	// execute side, held while dmrw_run is high
	input  logic       cmd_ld_ma,
	input  logic       cmd_st_ma,
	input  logic       wbk_rd_reg_ma,
	input  logic [4:0] rd_adr_ma,
	input  word_t      rd_data_ma,
	input  word_t      st_data_ma,
	input  ldst_code_t ldst_code_ma,
	// register writeback
	output logic [4:0] rd_adr_wb,
	output logic       wbk_rd_reg_wb,
	output word_t      wbk_data_wb,
	// data memory port
	output logic       d_read_req,
	output logic       d_read_w,
	output logic       d_read_hw,
	output word_t      d_read_adr,
	input  logic       read_valid,
	input  word_t      read_data,
	output logic       d_write_req,
	output logic       d_write_w,
	output logic       d_write_hw,
	output word_t      d_write_adr,
	output word_t      d_write_data,
	input  logic       write_finish,
	// IO register block
	output logic        dma_io_we,
	output logic [15:2] dma_io_wadr,
	output word_t       dma_io_wdata,
	output logic [15:2] dma_io_radr,
	output logic        dma_io_radr_en,
	input  word_t       dma_io_rdata,
	// sequencer
	input  logic       cpu_stat_dmrw,
	output logic       dmrw_run
);

	dat_state_t data_state;
	dat_state_t next_data_state;
	logic       sel_io;
	logic       sel_mem;
	logic       req_w;
	logic       req_hw;
	logic       reg_only;
	logic       acc_done;
	logic       can_issue;
	logic       dma_io_ren_wb;

	// top two address bits pick the target
	assign sel_io  = (rd_data_ma[31:30] == `DMRW_IO_REGION);
	assign sel_mem = ~sel_io;
	assign req_w   = (ldst_code_ma == LDST_WORD) & sel_mem;
	assign req_hw  = (ldst_code_ma == LDST_HALF) & sel_mem;

	assign d_read_req   = cmd_ld_ma & sel_mem;
	assign d_read_w     = req_w;
	assign d_read_hw    = req_hw;
	assign d_read_adr   = rd_data_ma;
	assign d_write_req  = cmd_st_ma & sel_mem;
	assign d_write_w    = req_w;
	assign d_write_hw   = req_hw;
	assign d_write_adr  = rd_data_ma;
	assign d_write_data = st_data_ma;

	// only word stores reach the IO block
	assign dma_io_we      = cmd_st_ma & sel_io & (ldst_code_ma == LDST_WORD);
	assign dma_io_wadr    = rd_data_ma[15:2];
	assign dma_io_wdata   = st_data_ma;
	assign dma_io_radr    = rd_data_ma[15:2];
	assign dma_io_radr_en = cmd_ld_ma & sel_io;

	// one access per held instruction
	assign can_issue = cpu_stat_dmrw & ~acc_done;

	always_comb begin
		next_data_state = DAT_IDLE;
		case (data_state)
			DAT_IDLE: begin
				if (can_issue & d_read_req)
					next_data_state = DAT_READ;
				else if (can_issue & d_write_req)
					next_data_state = DAT_WRTE;
				else if (can_issue & dma_io_radr_en)
					next_data_state = DAT_IOR1;
				else if (can_issue & dma_io_we)
					next_data_state = DAT_IOWT;
			end
			DAT_READ: next_data_state = read_valid ? DAT_IDLE : DAT_READ;
			DAT_WRTE: next_data_state = write_finish ? DAT_IDLE : DAT_WRTE;
			DAT_IOR1: next_data_state = DAT_IOR2;
			default:  next_data_state = DAT_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			data_state    <= DAT_IDLE;
			acc_done      <= 1'b0;
			dma_io_ren_wb <= 1'b0;
		end else begin
			data_state    <= next_data_state;
			dma_io_ren_wb <= dma_io_radr_en;
			// blocks a restart until the sequencer drops the instruction
			if (!cpu_stat_dmrw)
				acc_done <= 1'b0;
			else if ((data_state != DAT_IDLE) && (next_data_state == DAT_IDLE))
				acc_done <= 1'b1;
		end
	end

	assign dmrw_run = (data_state != DAT_IDLE) | (next_data_state != DAT_IDLE);

	// writeback: IO data, then memory data, then pass-through result
	assign reg_only      = wbk_rd_reg_ma & ~cmd_ld_ma & ~cmd_st_ma;
	assign wbk_data_wb   = dma_io_ren_wb ? dma_io_rdata :
	                       dmrw_run      ? read_data    : rd_data_ma;
	assign wbk_rd_reg_wb = dma_io_ren_wb | (read_valid & dmrw_run) |
	                       (reg_only & cpu_stat_dmrw & (next_data_state == DAT_IDLE));
	assign rd_adr_wb     = rd_adr_ma;

endmodule

// File: logic/qspi_data_port.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// wait-state data memory behind the serial flash style port
// request edge detect, wait counter, byte lane merge and extract
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "dmrw_cfg.svh"

module qspi_data_port import dmrw_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  d_read_req,
	input  logic  d_read_w,
	input  logic  d_read_hw,
	input  word_t d_read_adr,
	input  logic  d_write_req,
	input  logic  d_write_w,
	input  logic  d_write_hw,
	input  word_t d_write_adr,
	input  word_t d_write_data,
	output logic  read_valid,
	output word_t read_data,
	output logic  write_finish
);

	localparam int MEM_AW = $clog2(`DMRW_MEM_WORDS);
	localparam int CNT_W  = $clog2(`DMRW_MEM_WAIT + 1);

	word_t             mem [0:`DMRW_MEM_WORDS-1];
	logic              rd_req_d;
	logic              wr_req_d;
	logic              rd_rise;
	logic              wr_rise;
	logic [CNT_W-1:0]  wait_cnt;
	logic              op_wr;
	logic              acc_done;
	word_t             op_adr;
	word_t             op_data;
	logic              op_w;
	logic              op_hw;
	logic [MEM_AW-1:0] widx;
	logic [3:0]        wr_be;
	word_t             wr_lanes;
	word_t             rword;

	assign rd_rise  = d_read_req & ~rd_req_d;
	assign wr_rise  = d_write_req & ~wr_req_d;
	assign acc_done = (wait_cnt == CNT_W'(1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_req_d     <= 1'b0;
			wr_req_d     <= 1'b0;
			wait_cnt     <= '0;
			op_wr        <= 1'b0;
			read_valid   <= 1'b0;
			write_finish <= 1'b0;
		end else begin
			rd_req_d     <= d_read_req;
			wr_req_d     <= d_write_req;
			read_valid   <= acc_done & ~op_wr;
			write_finish <= acc_done & op_wr;
			if (rd_rise | wr_rise) begin
				wait_cnt <= CNT_W'(`DMRW_MEM_WAIT - 1);
				op_wr    <= wr_rise & ~rd_rise;
			end else if (wait_cnt != '0) begin
				wait_cnt <= wait_cnt - CNT_W'(1);
			end
		end
	end

	// capture the access when it starts
	always_ff @(posedge clk) begin
		if (rd_rise | wr_rise) begin
			op_adr  <= rd_rise ? d_read_adr : d_write_adr;
			op_w    <= rd_rise ? d_read_w : d_write_w;
			op_hw   <= rd_rise ? d_read_hw : d_write_hw;
			op_data <= d_write_data;
		end
	end

	assign widx  = op_adr[MEM_AW+1:2];
	assign rword = mem[widx];

	// lane enables, data replicated across lanes
	always_comb begin
		if (op_w) begin
			wr_be    = 4'hf;
			wr_lanes = op_data;
		end else if (op_hw) begin
			wr_be    = op_adr[1] ? 4'hc : 4'h3;
			wr_lanes = {2{op_data[15:0]}};
		end else begin
			wr_be    = 4'b0001 << op_adr[1:0];
			wr_lanes = {4{op_data[7:0]}};
		end
	end

	always_ff @(posedge clk) begin
		if (acc_done & op_wr) begin
			for (int i = 0; i < 4; i++) begin
				if (wr_be[i])
					mem[widx][8*i +: 8] <= wr_lanes[8*i +: 8];
			end
		end
		// sub-word reads come back zero-extended at bit 0
		if (acc_done & ~op_wr) begin
			if (op_w)
				read_data <= rword;
			else if (op_hw)
				read_data <= {16'h0, (op_adr[1] ? rword[31:16] : rword[15:0])};
			else
				read_data <= {24'h0, rword[8*op_adr[1:0] +: 8]};
		end
	end

endmodule

// File: logic/io_regs.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// IO register block
// word-wide registers, whole word writes, registered read port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "dmrw_cfg.svh"

module io_regs import dmrw_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        dma_io_we,
	input  logic [15:2] dma_io_wadr,
	input  word_t       dma_io_wdata,
	input  logic [15:2] dma_io_radr,
	input  logic        dma_io_radr_en,
	output word_t       dma_io_rdata
);

	localparam int IO_AW = $clog2(`DMRW_IO_REGS);

	word_t            regs [0:`DMRW_IO_REGS-1];
	logic [IO_AW-1:0] widx;
	logic [IO_AW-1:0] ridx;

	// only the low word address bits decode, upper bits alias
	assign widx = dma_io_wadr[IO_AW+1:2];
	assign ridx = dma_io_radr[IO_AW+1:2];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `DMRW_IO_REGS; i++)
				regs[i] <= '0;
		end else if (dma_io_we) begin
			regs[widx] <= dma_io_wdata;
		end
	end

	// read data lands the cycle after the enable
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			dma_io_rdata <= '0;
		else if (dma_io_radr_en)
			dma_io_rdata <= regs[ridx];
	end

endmodule

// File: logic/dmrw_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data access top level
// stage, data memory port and IO register block
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module dmrw_top import dmrw_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       cmd_ld_ma,
	input  logic       cmd_st_ma,
	input  logic       wbk_rd_reg_ma,
	input  logic [4:0] rd_adr_ma,
	input  word_t      rd_data_ma,
	input  word_t      st_data_ma,
	input  ldst_code_t ldst_code_ma,
	input  logic       cpu_stat_dmrw,
	output logic [4:0] rd_adr_wb,
	output logic       wbk_rd_reg_wb,
	output word_t      wbk_data_wb,
	output logic       dmrw_run
);

	// memory port wires
	logic  d_read_req;
	logic  d_read_w;
	logic  d_read_hw;
	word_t d_read_adr;
	logic  read_valid;
	word_t read_data;
	logic  d_write_req;
	logic  d_write_w;
	logic  d_write_hw;
	word_t d_write_adr;
	word_t d_write_data;
	logic  write_finish;

	// IO block wires
	logic        dma_io_we;
	logic [15:2] dma_io_wadr;
	word_t       dma_io_wdata;
	logic [15:2] dma_io_radr;
	logic        dma_io_radr_en;
	word_t       dma_io_rdata;

	data_rw_mem u_stage (.*);

	qspi_data_port u_mem (.*);

	io_regs u_io (.*);

endmodule

// File: tests/dmrw_checker.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// writeback checker for the data access stage
// per-cycle writeback compare, per-operation busy length, result counts
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module dmrw_checker import dmrw_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       wbk_rd_reg_wb,
	input  word_t      wbk_data_wb,
	input  logic [4:0] rd_adr_wb,
	input  logic       dmrw_run,
	input  logic       exp_wb,
	input  word_t      exp_data,
	input  logic [4:0] exp_adr,
	input  int         exp_run,
	input  int         op_id,
	input  int         test_id,
	input  logic       done,
	output int         checks,
	output int         errors
);

	int   last_op = 0;
	int   last_test = 0;
	int   test_err = 0;
	int   wb_seen = 0;
	int   run_seen = 0;
	int   op_run = 0;
	logic op_wb = 1'b0;
	bit   closed = 1'b0;

	initial begin
		checks = 0;
		errors = 0;
	end

	always @(posedge clk) begin
		if (rst_n && !closed) begin
			// an operation closes when the next one starts or the run ends
			if (op_id != last_op || done) begin
				if (last_op != 0) begin
					checks++;
					if (op_wb && wb_seen == 0) begin
						$display("Missing writeback: operation %0d wrote no register", last_op);
						errors++;
					end
					if (run_seen != op_run) begin
						$display("Error: time %0t, dmrw_run high for %0d cycles, expected %0d",
							$time, run_seen, op_run);
						errors++;
					end
				end
				last_op  = op_id;
				op_wb    = exp_wb;
				op_run   = exp_run;
				wb_seen  = 0;
				run_seen = 0;
			end
			if (test_id != last_test || done) begin
				if (last_test != 0)
					$display("test %0d finished, %0d errors", last_test, errors - test_err);
				last_test = test_id;
				test_err  = errors;
			end
			if (wbk_rd_reg_wb && !done) begin
				wb_seen++;
				checks++;
				if (!op_wb) begin
					$display("Unexpected writeback: operation %0d writes no register", op_id);
					errors++;
				end else begin
					if (wbk_data_wb !== exp_data) begin
						$display("Error: time %0t, wbk_data_wb = %h, expected %h",
							$time, wbk_data_wb, exp_data);
						errors++;
					end
					if (rd_adr_wb !== exp_adr) begin
						$display("Error: time %0t, rd_adr_wb = %0d, expected %0d",
							$time, rd_adr_wb, exp_adr);
						errors++;
					end
				end
			end
			if (dmrw_run)
				run_seen++;
			closed = done;
		end
	end

endmodule

// File: tests/tb_dmrw.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the data access top level
// clock, reset, sequencer-style stimulus, reference model, watchdog
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "dmrw_cfg.svh"

module tb_dmrw import dmrw_pkg::*; ();

	// 23 directed, 8 memory fill, then the random mix
	localparam int N_RAND = 40;
	localparam int N_OPS  = 31 + N_RAND;

	logic       clk;
	logic       rst_n;
	logic       cmd_ld_ma;
	logic       cmd_st_ma;
	logic       wbk_rd_reg_ma;
	logic [4:0] rd_adr_ma;
	word_t      rd_data_ma;
	word_t      st_data_ma;
	ldst_code_t ldst_code_ma;
	logic       cpu_stat_dmrw;
	logic [4:0] rd_adr_wb;
	logic       wbk_rd_reg_wb;
	word_t      wbk_data_wb;
	logic       dmrw_run;
	logic       exp_wb;
	word_t      exp_data;
	logic [4:0] exp_adr;
	int         exp_run;
	int         op_id;
	int         test_id;
	logic       done;
	int         checks;
	int         errors;
	word_t      mem_sh [0:`DMRW_MEM_WORDS-1];
	word_t      io_sh [0:`DMRW_IO_REGS-1];
	int         seed = 32'h3fb7;

	dmrw_top DUT (.*);

	dmrw_checker chk (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		repeat (10 + N_OPS * (`DMRW_MEM_WAIT + 4) + 200) @(posedge clk);
		$display("Timeout: the operations did not finish in time");
		$display("Test failed");
		$finish;
	end

	// expected writeback value and flag, stores update the shadow state
	function automatic bit ref_access(input bit ld, input bit st, input bit rw,
		input word_t adr, input word_t dat, input ldst_code_t code, output word_t val);
		int    sh;
		word_t mask;
		val  = adr;
		mask = (code == LDST_BYTE) ? 32'hff : (code == LDST_HALF) ? 32'hffff : 32'hffff_ffff;
		sh   = (code == LDST_BYTE) ? 8 * adr[1:0] : (code == LDST_HALF) ? 16 * adr[1] : 0;
		if (adr[31:30] == `DMRW_IO_REGION && (ld || st)) begin
			if (st && code == LDST_WORD)
				io_sh[adr[5:2]] = dat;
			val = io_sh[adr[5:2]];
		end else if (st) begin
			mem_sh[adr[9:2]] = (mem_sh[adr[9:2]] & ~(mask << sh)) | ((dat & mask) << sh);
		end else if (ld) begin
			val = (mem_sh[adr[9:2]] >> sh) & mask;
		end
		return ld || (rw && !st);
	endfunction

	task automatic do_op(input bit ld, input bit st, input bit rw, input logic [4:0] rd,
		input word_t adr, input word_t dat, input ldst_code_t code);
		word_t v;
		bit    io;
		io       = (adr[31:30] == `DMRW_IO_REGION);
		exp_wb   = ref_access(ld, st, rw, adr, dat, code, v);
		exp_data = v;
		exp_adr  = rd;
		// busy cycles as seen at rising edges
		if (!ld && !st)
			exp_run = 0;
		else if (!io)
			exp_run = `DMRW_MEM_WAIT + 1;
		else if (ld)
			exp_run = 3;
		else
			exp_run = (code == LDST_WORD) ? 2 : 0;
		op_id++;
		cmd_ld_ma     = ld;
		cmd_st_ma     = st;
		wbk_rd_reg_ma = rw;
		rd_adr_ma     = rd;
		rd_data_ma    = adr;
		st_data_ma    = dat;
		ldst_code_ma  = code;
		cpu_stat_dmrw = 1'b1;
		do
			@(negedge clk);
		while (dmrw_run);
		cmd_ld_ma     = 1'b0;
		cmd_st_ma     = 1'b0;
		wbk_rd_reg_ma = 1'b0;
		cpu_stat_dmrw = 1'b0;
		@(negedge clk);
	endtask

	task automatic random_op();
		word_t      r;
		word_t      hi;
		word_t      d;
		word_t      adr;
		ldst_code_t code;
		logic [1:0] off;
		r    = $random(seed);
		hi   = $random(seed);
		d    = $random(seed);
		code = (r[1:0] == 2'd3) ? LDST_WORD : ldst_code_t'(r[1:0]);
		off  = (code == LDST_WORD) ? 2'b00 : (code == LDST_HALF) ? {r[3], 1'b0} : r[3:2];
		// IO registers 0 to 7, memory words 8 to 15
		if (r[7:6] == 2'd0)
			adr = {2'b11, hi[29:6], 1'b0, r[11:9], off};
		else
			adr = {(hi[31:30] == 2'd3) ? 2'd1 : hi[31:30], hi[29:10], 5'd1, r[11:9], off};
		if (r[5:4] == 2'd0)
			do_op(0, 0, 1, hi[4:0], d, 32'h0, code);
		else
			do_op(r[8], !r[8], r[8], hi[4:0], adr, d, code);
	endtask

	initial begin
		rst_n         = 1'b0;
		cmd_ld_ma     = 1'b0;
		cmd_st_ma     = 1'b0;
		wbk_rd_reg_ma = 1'b0;
		rd_adr_ma     = 5'd0;
		rd_data_ma    = '0;
		st_data_ma    = '0;
		ldst_code_ma  = LDST_WORD;
		cpu_stat_dmrw = 1'b0;
		exp_wb        = 1'b0;
		exp_data      = '0;
		exp_adr       = 5'd0;
		exp_run       = 0;
		op_id         = 0;
		test_id       = 0;
		done          = 1'b0;
		for (int i = 0; i < `DMRW_IO_REGS; i++)
			io_sh[i] = '0;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		test_id = 1;
		do_op(0, 0, 1, 5'd1, 32'h1234_5678, 32'h0, LDST_WORD);
		do_op(0, 0, 1, 5'd31, 32'hc000_0004, 32'h0, LDST_BYTE);
		do_op(0, 0, 1, 5'd7, 32'hffff_ffff, 32'h0, LDST_HALF);
		test_id = 2;
		do_op(0, 1, 0, 5'd0, 32'h0000_0040, 32'hdead_beef, LDST_WORD);
		do_op(1, 0, 1, 5'd2, 32'h0000_0040, 32'h0, LDST_WORD);
		// wraps onto word 1
		do_op(0, 1, 0, 5'd0, 32'h8000_0404, 32'h0bad_f00d, LDST_WORD);
		do_op(1, 0, 1, 5'd3, 32'h0000_0004, 32'h0, LDST_WORD);
		test_id = 3;
		do_op(0, 1, 0, 5'd0, 32'h4000_0080, 32'h1122_3344, LDST_WORD);
		do_op(0, 1, 0, 5'd0, 32'h4000_0082, 32'h0000_aa55, LDST_HALF);
		do_op(0, 1, 0, 5'd0, 32'h4000_0081, 32'h0000_00c3, LDST_BYTE);
		do_op(1, 0, 1, 5'd4, 32'h4000_0080, 32'h0, LDST_WORD);
		do_op(1, 0, 1, 5'd5, 32'h4000_0080, 32'h0, LDST_HALF);
		do_op(1, 0, 1, 5'd6, 32'h4000_0082, 32'h0, LDST_HALF);
		do_op(1, 0, 1, 5'd8, 32'h4000_0081, 32'h0, LDST_BYTE);
		do_op(1, 0, 1, 5'd9, 32'h4000_0083, 32'h0, LDST_BYTE);
		test_id = 4;
		do_op(0, 1, 0, 5'd0, 32'hc000_000c, 32'hcafe_0123, LDST_WORD);
		do_op(1, 0, 1, 5'd10, 32'hc000_000c, 32'h0, LDST_WORD);
		do_op(1, 0, 1, 5'd11, 32'hc000_000e, 32'h0, LDST_HALF);
		do_op(1, 0, 1, 5'd12, 32'hc000_000d, 32'h0, LDST_BYTE);
		do_op(0, 1, 0, 5'd0, 32'hc000_000c, 32'h0000_00ff, LDST_BYTE);
		do_op(1, 0, 1, 5'd13, 32'hc000_000c, 32'h0, LDST_WORD);
		test_id = 5;
		for (int i = 8; i < 16; i++)
			do_op(0, 1, 0, 5'd0, 32'(i) << 2, $random(seed), LDST_WORD);
		for (int i = 0; i < N_RAND; i++)
			random_op();
		test_id = 6;
		do_op(1, 0, 1, 5'd14, 32'hc000_003c, 32'h0, LDST_WORD);
		do_op(1, 0, 1, 5'd15, 32'hc000_0038, 32'h0, LDST_BYTE);
		done = 1'b1;
		repeat (3) @(negedge clk);
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: all.f
+incdir+logic
logic/dmrw_pkg.sv
logic/data_rw_mem.sv
logic/qspi_data_port.sv
logic/io_regs.sv
logic/dmrw_top.sv
tests/dmrw_checker.sv
tests/tb_dmrw.sv
